//--- source/fm_mix_pkg.sv
// FM and ADPCM mixing stage, shared definitions
// Sample widths, frame layout constants and the register handshake states
package fm_mix_pkg;

    // Sample widths
    typedef logic signed [13:0] op_sample_t;   // Operator engine result
    typedef logic signed [15:0] mix_sample_t;  // ADPCM input, mixed output
    typedef logic signed [20:0] acc_word_t;    // 24 additions of headroom

    // Slot addressing
    typedef logic [2:0] ch_code_t;             // Codes 0-2 and 4-6 in use
    typedef logic [1:0] op_idx_t;              // Slot order S1, S3, S2, S4

    // Per-channel voice settings
    typedef logic [2:0] alg_t;                 // Connection algorithm
    typedef logic [1:0] pan_t;                 // [1] left, [0] right

    // Host write handshake
    typedef enum logic {
        IDLE,                                  // Waiting for req
        ACK                                    // Written, waiting for req low
    } reg_state_t;

    // Frame layout
    localparam int SLOTS_PER_FRAME = 24;       // 6 channels x 4 operators
    localparam int SLOTS_PER_OP    = SLOTS_PER_FRAME / 4;  // Channels per operator

    // Channels whose first slot carries ADPCM instead of FM
    localparam ch_code_t ADPCM_A_CH = 3'd2;
    localparam ch_code_t ADPCM_B_CH = 3'd6;

    // Both sides enabled out of reset
    localparam pan_t PAN_RESET = 2'd3;

endpackage

//--- source/slot_sequencer.sv
// Slot sequencer
// Walks the 24 operator slots of a frame, one per clk_en, and shows the
// channel code, operator index, operator strobes and frame start
`timescale 1ns/1ps

module slot_sequencer import fm_mix_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     clk_en,
    output ch_code_t cur_ch,
    output op_idx_t  cur_op,
    output logic     frame_start,
    output logic     s1_enters,
    output logic     s2_enters,
    output logic     s3_enters,
    output logic     s4_enters
);

    logic [4:0] slot_cnt;   // Slot currently shown
    logic [4:0] slot_nxt;
    logic [4:0] pos_nxt;    // Channel position 0-5
    op_idx_t    op_nxt;
    ch_code_t   ch_nxt;

    // Decode of the slot about to be shown
    always_comb begin
        slot_nxt = (int'(slot_cnt) == SLOTS_PER_FRAME - 1) ? 5'd0 : slot_cnt + 5'd1;

        if (int'(slot_nxt) < SLOTS_PER_OP)
            op_nxt = 2'd0;                          // S1
        else if (int'(slot_nxt) < 2 * SLOTS_PER_OP)
            op_nxt = 2'd1;                          // S3
        else if (int'(slot_nxt) < 3 * SLOTS_PER_OP)
            op_nxt = 2'd2;                          // S2
        else
            op_nxt = 2'd3;                          // S4

        pos_nxt = slot_nxt - 5'(op_nxt) * 5'(SLOTS_PER_OP);

        // Code 3 skipped so positions 3-5 become codes 4-6
        ch_nxt = (pos_nxt < 5'd3) ? pos_nxt[2:0] : pos_nxt[2:0] + 3'd1;
    end

    // Outputs registered from the next decode so they match slot_cnt
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_cnt    <= '0;
            cur_ch      <= '0;
            cur_op      <= '0;
            frame_start <= 1'b1;   // Slot 0 shown from reset
            s1_enters   <= 1'b1;
            s3_enters   <= 1'b0;
            s2_enters   <= 1'b0;
            s4_enters   <= 1'b0;
        end else if (clk_en) begin
            slot_cnt    <= slot_nxt;
            cur_ch      <= ch_nxt;
            cur_op      <= op_nxt;
            frame_start <= (slot_nxt == 5'd0);
            s1_enters   <= (op_nxt == 2'd0);
            s3_enters   <= (op_nxt == 2'd1);
            s2_enters   <= (op_nxt == 2'd2);
            s4_enters   <= (op_nxt == 2'd3);
        end
    end

    // Exactly one operator role per slot
    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot({s1_enters, s2_enters, s3_enters, s4_enters}));

endmodule

//--- source/voice_regs.sv
// Voice register file
// Algorithm and pan per channel, written by the host over a four-phase
// req/ack port and read combinationally by channel code
`timescale 1ns/1ps

module voice_regs import fm_mix_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // Host write port
    input  logic       req,
    input  ch_code_t   wr_ch,
    input  logic [4:0] wr_data,   // [4:2] alg, [1:0] pan
    output logic       ack,
    // Slot read port
    input  ch_code_t   rd_ch,
    output alg_t       alg,
    output pan_t       pan
);

    alg_t       alg_r [6];
    pan_t       pan_r [6];
    reg_state_t state;
    logic [2:0] wr_idx;
    logic [2:0] rd_idx;
    logic       wr_valid;
    logic       rd_valid;

    // Codes 4-6 fold down onto entries 3-5
    function automatic logic [2:0] ch_index(ch_code_t ch);
        return ch - {2'b00, ch[2]};
    endfunction

    assign wr_idx   = ch_index(wr_ch);
    assign rd_idx   = ch_index(rd_ch);
    assign wr_valid = (wr_ch[1:0] != 2'b11);   // Codes 3 and 7 unused
    assign rd_valid = (rd_ch[1:0] != 2'b11);

    // Handshake FSM and register write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            for (int i = 0; i < 6; i++) begin
                alg_r[i] <= '0;
                pan_r[i] <= PAN_RESET;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        if (wr_valid) begin
                            alg_r[wr_idx] <= wr_data[4:2];
                            pan_r[wr_idx] <= wr_data[1:0];
                        end
                        state <= ACK;   // Ack even for ignored codes
                    end
                end
                ACK: begin
                    if (!req)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign ack = (state == ACK);

    // Current slot's channel settings
    always_comb begin
        if (rd_valid) begin
            alg = alg_r[rd_idx];
            pan = pan_r[rd_idx];
        end else begin
            alg = '0;   // Never shown by the sequencer
            pan = '0;
        end
    end

    // Ack only answers a request seen on the previous edge
    a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req));

    // Host holds req until the write is acknowledged
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        (req && !ack) |=> req);

endmodule

//--- source/frame_acc.sv
// Frame accumulator for one output side
// Sums enabled samples over a frame, then saturates the total to 16 bits
// and holds it for the whole next frame
`timescale 1ns/1ps

module frame_acc import fm_mix_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_en,
    input  mix_sample_t sample,
    input  logic        add_en,
    input  logic        frame_start,
    output mix_sample_t snd
);

    acc_word_t   acc;
    acc_word_t   contrib;   // This slot's share
    mix_sample_t acc_sat;

    assign contrib = add_en ? acc_word_t'(sample) : '0;   // Sign-extending cast

    // Clamp to the 16-bit range
    always_comb begin
        if (acc > acc_word_t'(32767))
            acc_sat = 16'sh7FFF;
        else if (acc < acc_word_t'(-32768))
            acc_sat = 16'sh8000;
        else
            acc_sat = acc[15:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (frame_start) begin
                snd <= acc_sat;   // Previous frame's total
                acc <= contrib;   // New frame opens with slot 0
            end else begin
                acc <= acc + contrib;
            end
        end
    end

endmodule

//--- source/fm_adpcm_mixer.sv
// FM and ADPCM mixer
// Picks the carrier operators of each channel by algorithm and pan, puts
// ADPCM-A and ADPCM-B into their fixed slots, and feeds both accumulators
`timescale 1ns/1ps

module fm_adpcm_mixer import fm_mix_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_en,
    input  op_sample_t  op_result,
    input  ch_code_t    cur_ch,
    input  op_idx_t     cur_op,
    input  logic        frame_start,
    input  logic        s1_enters,
    input  logic        s2_enters,
    input  logic        s4_enters,
    input  alg_t        alg,
    input  pan_t        pan,
    input  mix_sample_t adpcm_a_l,
    input  mix_sample_t adpcm_a_r,
    input  mix_sample_t adpcm_b_l,
    input  mix_sample_t adpcm_b_r,
    output mix_sample_t left,
    output mix_sample_t right
);

    logic        carrier;          // Slot is an output operator
    mix_sample_t op_ext;
    mix_sample_t in_l, in_r;
    logic        en_l, en_r;

    // ADPCM-A: 12-bit range, scaled by 4, clamped outside it
    function automatic mix_sample_t scale_adpcm_a(mix_sample_t x);
        if (x < -16'sd2048)
            return 16'shE000;      // -8192
        else if (x > 16'sd2047)
            return 16'sh1FFF;      // 8191
        else
            return x <<< 2;
    endfunction

    // Carrier gate per connection algorithm
    always_comb begin
        case (alg)
            3'd4:       carrier = s2_enters | s4_enters;
            3'd5, 3'd6: carrier = ~s1_enters;
            3'd7:       carrier = 1'b1;
            default:    carrier = s4_enters;   // Algorithms 0-3
        endcase
    end

    assign op_ext = {{2{op_result[13]}}, op_result};

    // FM data is dropped in the two ADPCM slots
    always_comb begin
        if (cur_op == 2'd0 && cur_ch == ADPCM_A_CH) begin
            in_l = scale_adpcm_a(adpcm_a_l);
            in_r = scale_adpcm_a(adpcm_a_r);
            en_l = 1'b1;                        // Pan ignored
            en_r = 1'b1;
        end else if (cur_op == 2'd0 && cur_ch == ADPCM_B_CH) begin
            in_l = adpcm_b_l >>> 2;             // Down to operator scale
            in_r = adpcm_b_r >>> 2;
            en_l = 1'b1;
            en_r = 1'b1;
        end else begin
            in_l = op_ext;
            in_r = op_ext;
            en_l = carrier & pan[1];
            en_r = carrier & pan[0];
        end
    end

    frame_acc u_left (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .sample      (in_l),
        .add_en      (en_l),
        .frame_start (frame_start),
        .snd         (left)
    );

    frame_acc u_right (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .sample      (in_r),
        .add_en      (en_r),
        .frame_start (frame_start),
        .snd         (right)
    );

    // ADPCM slots sit on S1, so the sequencer's op index and strobe must agree
    a_op0_is_s1: assert property (@(posedge clk) disable iff (!arst_n)
        (cur_op == 2'd0) == s1_enters);

endmodule

//--- source/fm_mix_top.sv
// FM and ADPCM output stage, top level
// Slot sequencer, voice registers and mixer with saturating accumulators
`timescale 1ns/1ps

module fm_mix_top import fm_mix_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_en,
    input  op_sample_t  op_result,    // Operator engine output for the shown slot
    input  mix_sample_t adpcm_a_l,
    input  mix_sample_t adpcm_a_r,
    input  mix_sample_t adpcm_b_l,
    input  mix_sample_t adpcm_b_r,
    input  logic        req,          // Host write port
    input  ch_code_t    wr_ch,
    input  logic [4:0]  wr_data,
    output logic        ack,
    output ch_code_t    cur_ch,       // Slot shown to the operator engine
    output op_idx_t     cur_op,
    output logic        frame_start,
    output mix_sample_t left,
    output mix_sample_t right
);

    logic s1_enters;
    logic s2_enters;
    logic s4_enters;
    alg_t alg;
    pan_t pan;

    slot_sequencer u_seq (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .cur_ch      (cur_ch),
        .cur_op      (cur_op),
        .frame_start (frame_start),
        .s1_enters   (s1_enters),
        .s2_enters   (s2_enters),
        .s3_enters   (),             // S3 never a lone carrier
        .s4_enters   (s4_enters)
    );

    voice_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .wr_ch   (wr_ch),
        .wr_data (wr_data),
        .ack     (ack),
        .rd_ch   (cur_ch),
        .alg     (alg),
        .pan     (pan)
    );

    fm_adpcm_mixer u_mix (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .op_result   (op_result),
        .cur_ch      (cur_ch),
        .cur_op      (cur_op),
        .frame_start (frame_start),
        .s1_enters   (s1_enters),
        .s2_enters   (s2_enters),
        .s4_enters   (s4_enters),
        .alg         (alg),
        .pan         (pan),
        .adpcm_a_l   (adpcm_a_l),
        .adpcm_a_r   (adpcm_a_r),
        .adpcm_b_l   (adpcm_b_l),
        .adpcm_b_r   (adpcm_b_r),
        .left        (left),
        .right       (right)
    );

endmodule

//--- testbench/tb_fm_mix_top.sv
// Testbench for the FM and ADPCM output stage
// Random slot stimulus, host writes over req/ack, and a frame-level
// reference model checked against the held left and right outputs
`timescale 1ns/1ps

module tb_fm_mix_top import fm_mix_pkg::*; ();

    logic        clk;
    logic        arst_n;
    logic        clk_en;
    op_sample_t  op_result;
    mix_sample_t adpcm_a_l;
    mix_sample_t adpcm_a_r;
    mix_sample_t adpcm_b_l;
    mix_sample_t adpcm_b_r;
    logic        req;
    ch_code_t    wr_ch;
    logic [4:0]  wr_data;
    logic        ack;
    ch_code_t    cur_ch;
    op_idx_t     cur_op;
    logic        frame_start;
    mix_sample_t left;
    mix_sample_t right;

    // Host-side copy of the voice registers by channel code
    logic [7:0][2:0]   alg_m;
    logic [7:0][1:0]   pan_m;
    logic [23:0][13:0] frame_ops;   // Op results of one frame in slot order
    logic [31:0]       exp_q [$];   // {left, right} per finished frame
    logic [31:0]       rng;
    int                op_mode;     // 0 small, 1 full, 2 max, 3 min
    int                checks_done;
    int                frames_done;

    fm_mix_top i_fm_mix_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .op_result   (op_result),
        .adpcm_a_l   (adpcm_a_l),
        .adpcm_a_r   (adpcm_a_r),
        .adpcm_b_l   (adpcm_b_l),
        .adpcm_b_r   (adpcm_b_r),
        .req         (req),
        .wr_ch       (wr_ch),
        .wr_data     (wr_data),
        .ack         (ack),
        .cur_ch      (cur_ch),
        .cur_op      (cur_op),
        .frame_start (frame_start),
        .left        (left),
        .right       (right)
    );

    always #5 clk = ~clk;   // 10 ns period

    task automatic stop_with_failure(string reason);
        $display("Error at %0t: %s", $time, reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(string name, logic signed [31:0] actual,
                               logic signed [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %0d, expected %0d",
                     $time, name, actual, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Channel position 0-5 to channel code with code 3 skipped
    function automatic ch_code_t pos_to_ch(int pos);
        return (pos < 3) ? 3'(pos) : 3'(pos + 1);
    endfunction

    function automatic int slot_of(ch_code_t ch, op_idx_t op);
        if (ch[1:0] == 2'b11)
            return -1;   // Code never shown in a frame
        return int'(op) * 6 + ((ch < 3'd3) ? int'(ch) : int'(ch) - 1);
    endfunction

    function automatic int adpcm_a_ref(int x);
        if (x < -2048)
            return -8192;
        if (x > 2047)
            return 8191;
        return x * 4;
    endfunction

    function automatic logic [15:0] sat16(int x);
        if (x > 32767)
            return 16'h7FFF;
        if (x < -32768)
            return 16'h8000;
        return 16'(x);
    endfunction

    // Expected {left, right} for one frame of recorded slots
    function automatic logic [31:0] mix_ref(logic [23:0][13:0] ops,
                                            logic [7:0][2:0] algs,
                                            logic [7:0][1:0] pans,
                                            int a_l, int a_r, int b_l, int b_r);
        int       sum_l;
        int       sum_r;
        int       op;
        int       v;
        ch_code_t ch;
        logic     carrier;
        sum_l = 0;
        sum_r = 0;
        for (int s = 0; s < SLOTS_PER_FRAME; s++) begin
            op = s / 6;                         // 0 S1, 1 S3, 2 S2, 3 S4
            ch = pos_to_ch(s % 6);
            v  = int'($signed(ops[s]));
            if (op == 0 && ch == ADPCM_A_CH) begin
                sum_l += adpcm_a_ref(a_l);      // Both sides regardless of pan
                sum_r += adpcm_a_ref(a_r);
            end else if (op == 0 && ch == ADPCM_B_CH) begin
                sum_l += b_l >>> 2;
                sum_r += b_r >>> 2;
            end else begin
                case (algs[ch])
                    3'd4:       carrier = (op == 2) || (op == 3);
                    3'd5, 3'd6: carrier = (op != 0);
                    3'd7:       carrier = 1'b1;
                    default:    carrier = (op == 3);   // S4 only
                endcase
                if (carrier && pans[ch][1])
                    sum_l += v;
                if (carrier && pans[ch][0])
                    sum_r += v;
            end
        end
        return {sat16(sum_l), sat16(sum_r)};
    endfunction

    // One frame from shown slot 0 until frozen on the next slot 0
    task automatic run_frame(int a_l, int a_r, int b_l, int b_r);
        int          count;
        int          cycles;
        logic [13:0] val;
        count  = 0;
        cycles = 0;
        check_value("frame_start", frame_start, 1);
        adpcm_a_l = 16'(a_l);   // ADPCM moves only at frame start
        adpcm_a_r = 16'(a_r);
        adpcm_b_l = 16'(b_l);
        adpcm_b_r = 16'(b_r);
        while (count < SLOTS_PER_FRAME) begin
            rng    = xorshift32(rng);
            clk_en = (rng[1:0] != 2'b00);   // About 3 cycles in 4
            rng    = xorshift32(rng);
            case (op_mode)
                1:       val = rng[13:0];
                2:       val = 14'h1FFF;
                3:       val = 14'h2000;
                default: val = {{3{rng[10]}}, rng[10:0]};   // Small signed values
            endcase
            op_result = val;
            if (clk_en) begin
                check_value("slot", slot_of(cur_ch, cur_op), count);
                frame_ops[count] = val;
                count++;
            end
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 8 * SLOTS_PER_FRAME)
                stop_with_failure("frame did not complete within the cycle limit");
        end
        clk_en = 1'b0;
        exp_q.push_back(mix_ref(frame_ops, alg_m, pan_m, a_l, a_r, b_l, b_r));
        frames_done++;
    endtask

    // Four-phase write while slots are frozen
    task automatic write_reg(ch_code_t ch, alg_t alg, pan_t pan);
        int cycles;
        check_value("ack", ack, 0);
        req     = 1'b1;
        wr_ch   = ch;
        wr_data = {alg, pan};
        cycles  = 0;
        while (!ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 16)
                stop_with_failure("ack did not rise after req");
        end
        @(posedge clk);   // Req held over one edge that sees ack
        #1;
        req    = 1'b0;
        cycles = 0;
        while (ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 16)
                stop_with_failure("ack did not fall after req dropped");
        end
        if (ch[1:0] != 2'b11) begin   // Codes 3 and 7 hold nothing
            alg_m[ch] = alg;
            pan_m[ch] = pan;
        end
    endtask

    // Held outputs checked right after each frame-start edge
    always @(posedge clk) begin
        logic [31:0] exp_val;
        if (arst_n && clk_en && frame_start) begin
            #2;
            if (exp_q.size() == 0) begin
                stop_with_failure("output frame with no expected value queued");
            end else begin
                exp_val = exp_q.pop_front();
                check_value("left", left, $signed(exp_val[31:16]));
                check_value("right", right, $signed(exp_val[15:0]));
                checks_done++;
            end
        end
    end

    initial begin
        int cycles;
        clk         = 1'b0;
        arst_n      = 1'b0;
        clk_en      = 1'b0;
        op_result   = '0;
        adpcm_a_l   = '0;
        adpcm_a_r   = '0;
        adpcm_b_l   = '0;
        adpcm_b_r   = '0;
        req         = 1'b0;
        wr_ch       = '0;
        wr_data     = '0;
        rng         = 32'd73;
        op_mode     = 0;
        checks_done = 0;
        frames_done = 0;
        for (int i = 0; i < 8; i++) begin
            alg_m[i] = '0;
            pan_m[i] = PAN_RESET;
        end
        exp_q.push_back(32'd0);   // Nothing summed before the first frame

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("ack", ack, 0);
        check_value("left", left, 0);
        check_value("right", right, 0);
        check_value("cur_ch", cur_ch, 0);

        // Reset defaults give S4 only on both sides
        run_frame(0, 0, 0, 0);
        run_frame(100, -100, 400, -400);

        // Algorithms 0-5 and then 6, 7, 0-3 across the channels
        for (int k = 0; k < 6; k++)
            write_reg(pos_to_ch(k), 3'(k), 2'd3);
        run_frame(0, 0, 0, 0);
        for (int k = 0; k < 6; k++)
            write_reg(pos_to_ch(k), 3'((k + 6) % 8), 2'd3);
        run_frame(50, 60, -70, 80);

        // Pan routing with both ADPCM channels on pan 0
        write_reg(3'd0, 3'd7, 2'd1);
        write_reg(3'd1, 3'd7, 2'd2);
        write_reg(3'd2, 3'd7, 2'd0);
        write_reg(3'd4, 3'd7, 2'd3);
        write_reg(3'd5, 3'd7, 2'd2);
        write_reg(3'd6, 3'd7, 2'd0);
        run_frame(300, -300, -800, 800);

        // Every slot a carrier on both sides from here on
        for (int k = 0; k < 6; k++)
            write_reg(pos_to_ch(k), 3'd7, 2'd3);

        // ADPCM-A below, inside and above the 12-bit range
        run_frame(-3000, 1000, 0, 0);
        run_frame(2047, 5000, 0, 0);
        run_frame(-2048, -2049, 0, 0);

        // ADPCM-B shift and then saturation
        run_frame(0, 0, -7, 12345);
        run_frame(0, 0, -32768, 32767);
        op_mode = 2;
        run_frame(2047, 2047, 32767, 32767);
        op_mode = 3;
        run_frame(-2048, -2048, -32768, -32768);
        op_mode = 1;
        run_frame(500, -500, 1000, -1000);
        op_mode = 0;

        // Back-to-back writes where codes 3 and 7 are ignored
        write_reg(3'd0, 3'd4, 2'd2);
        write_reg(3'd1, 3'd5, 2'd1);
        write_reg(3'd4, 3'd0, 2'd3);
        write_reg(3'd3, 3'd7, 2'd0);
        write_reg(3'd7, 3'd7, 2'd0);
        run_frame(-1500, 1500, -2000, 2000);

        // One more frame-start edge shows the last frame
        clk_en = 1'b1;
        @(posedge clk);
        #1;
        clk_en = 1'b0;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 8)
                stop_with_failure("last frame result was never compared");
        end

        if (checks_done != frames_done + 1) begin
            stop_with_failure("number of compared frames does not match frames run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- files.f
source/fm_mix_pkg.sv
source/slot_sequencer.sv
source/voice_regs.sv
source/frame_acc.sv
source/fm_adpcm_mixer.sv
source/fm_mix_top.sv
testbench/tb_fm_mix_top.sv
